//--- hdl/twi_pkg.sv
package twi_pkg;

	// host command opcodes
	typedef enum logic [2:0] {
		OP_START     = 3'b000,
		OP_WRITE     = 3'b001,
		OP_READ_ACK  = 3'b010,
		OP_STOP      = 3'b011,
		OP_READ_NACK = 3'b100
	} twi_op_e;

	// one queued host command, wdata only matters for OP_WRITE
	typedef struct packed {
		twi_op_e    op;
		logic [7:0] wdata;
	} twi_cmd_t;

	// one finished command
	// ack is the level seen in the ninth bit of a write, 0 = acknowledged
	typedef struct packed {
		twi_op_e    op;
		logic [7:0] rdata;
		logic       ack;
	} twi_rsp_t;

	// bus timing, one SCL bit is BIT_PHASES quarter phases
	localparam int PHASE_CYC   = 5;
	localparam int PHASE_CNT_W = 3;
	localparam int BIT_PHASES  = 4;
	localparam int PHASE_IDX_W = $clog2(BIT_PHASES);

	// START and STOP run for three quarter phases
	localparam int CTRL_PHASES = 3;

	// eight data slots plus the acknowledge slot
	localparam int BYTE_BITS = 9;

	// command queue
	localparam int CMD_DEPTH = 4;
	localparam int QPTR_W    = $clog2(CMD_DEPTH);

	// compare values for the core counters
	localparam logic [PHASE_CNT_W-1:0] PHASE_LAST = PHASE_CNT_W'(PHASE_CYC - 1);
	localparam logic [PHASE_CNT_W-1:0] SAMPLE_CYC = PHASE_CNT_W'(PHASE_CYC / 2);

	localparam logic [PHASE_IDX_W-1:0] LAST_BIT_PHASE  = PHASE_IDX_W'(BIT_PHASES - 1);
	localparam logic [PHASE_IDX_W-1:0] LAST_CTRL_PHASE = PHASE_IDX_W'(CTRL_PHASES - 1);

	// slot index of the acknowledge bit
	localparam logic [3:0] ACK_SLOT = 4'(BYTE_BITS - 1);

endpackage

//--- hdl/twi_cmd_queue.sv
`timescale 1ns/1ps

module twi_cmd_queue (
	input  logic              clk,
	input  logic              rst,
	input  logic              cmd_valid_i,
	input  twi_pkg::twi_cmd_t cmd_i,
	input  logic              pop_i,
	output logic              valid_o,
	output twi_pkg::twi_cmd_t cmd_o,
	output logic              credit_o
);

	import twi_pkg::*;

	twi_cmd_t          mem [CMD_DEPTH];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QPTR_W:0]   count;

	// storage, the host never writes without a free entry
	always_ff @(posedge clk) begin
		if (cmd_valid_i) begin
			mem[wr_ptr] <= cmd_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (cmd_valid_i) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (pop_i) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({cmd_valid_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// one credit back per entry freed
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_o <= 1'b0;
		end else begin
			credit_o <= pop_i;
		end
	end

	assign valid_o = (count != '0);
	assign cmd_o   = mem[rd_ptr];

endmodule

//--- hdl/twi_byte_shift.sv
`timescale 1ns/1ps

module twi_byte_shift (
	input  logic             clk,
	input  logic             rst,
	input  logic             load_i,
	input  logic [7:0]       wdata_i,
	input  twi_pkg::twi_op_e op_i,
	input  logic             shift_i,
	input  logic             sample_i,
	input  logic [3:0]       bit_idx_i,
	input  logic             sda_i,
	output logic             tx_bit_o,
	output logic [7:0]       rdata_o,
	output logic             ack_o
);

	import twi_pkg::*;

	logic [7:0] tx_sr;
	logic [7:0] rx_sr;
	logic       ack_q;
	logic       is_read;
	logic       ack_slot;

	assign is_read  = (op_i == OP_READ_ACK) || (op_i == OP_READ_NACK);
	assign ack_slot = (bit_idx_i == ACK_SLOT);

	// msb first, ones shifted in so the line ends up released
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_sr <= 8'hff;
		end else if (load_i) begin
			tx_sr <= wdata_i;
		end else if (shift_i) begin
			tx_sr <= {tx_sr[6:0], 1'b1};
		end
	end

	// receive data bits only, cleared per command so non-reads report zero
	always_ff @(posedge clk) begin
		if (load_i) begin
			rx_sr <= 8'h00;
		end else if (sample_i && is_read && !ack_slot) begin
			rx_sr <= {rx_sr[6:0], sda_i};
		end
	end

	// slave acknowledge of a written byte
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else if (load_i) begin
			ack_q <= 1'b0;
		end else if (sample_i && (op_i == OP_WRITE) && ack_slot) begin
			ack_q <= sda_i;
		end
	end

	// enable value for the current slot, 1 releases the line
	always_comb begin
		case (op_i)
			OP_WRITE:    tx_bit_o = ack_slot ? 1'b1 : tx_sr[7];
			OP_READ_ACK: tx_bit_o = !ack_slot;
			default:     tx_bit_o = 1'b1;
		endcase
	end

	assign rdata_o = rx_sr;
	assign ack_o   = ack_q;

endmodule

//--- hdl/twi_core.sv
`timescale 1ns/1ps

module twi_core (
	input  logic              clk,
	input  logic              rst,
	input  logic              q_valid_i,
	input  twi_pkg::twi_cmd_t q_cmd_i,
	output logic              q_pop_o,
	input  logic              tx_bit_i,
	input  logic [7:0]        rdata_i,
	input  logic              ack_i,
	output logic              load_o,
	output logic [7:0]        wdata_o,
	output twi_pkg::twi_op_e  op_o,
	output logic              shift_o,
	output logic              sample_o,
	output logic [3:0]        bit_idx_o,
	output logic              scl_o,
	output logic              sda_oen_o,
	output logic              rsp_valid_o,
	output twi_pkg::twi_rsp_t rsp_o
);

	import twi_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		START,
		BYTE,
		STOP
	} state_e;

	state_e                 state;
	twi_op_e                cur_op;
	logic [PHASE_CNT_W-1:0] cyc_cnt;
	logic [PHASE_IDX_W-1:0] phase;
	logic [3:0]             bit_cnt;

	logic phase_end;
	logic slot_end;
	logic ctrl_end;
	logic byte_end;
	logic op_done;
	logic slot_begin;

	assign phase_end  = (cyc_cnt == PHASE_LAST);
	assign slot_end   = phase_end && (phase == LAST_BIT_PHASE);
	assign ctrl_end   = phase_end && (phase == LAST_CTRL_PHASE);
	assign byte_end   = slot_end && (bit_cnt == ACK_SLOT);
	assign slot_begin = (state == BYTE) && (phase == '0) && (cyc_cnt == '0);

	always_comb begin
		case (state)
			START, STOP: op_done = ctrl_end;
			BYTE:        op_done = byte_end;
			default:     op_done = 1'b0;
		endcase
	end

	// take a new command only when the bus is free
	assign q_pop_o = (state == IDLE) && q_valid_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			cyc_cnt <= '0;
			phase   <= '0;
			bit_cnt <= '0;
		end else if (state == IDLE) begin
			cyc_cnt <= '0;
			phase   <= '0;
			bit_cnt <= '0;
			if (q_valid_i) begin
				case (q_cmd_i.op)
					OP_START: state <= START;
					OP_STOP:  state <= STOP;
					default:  state <= BYTE;
				endcase
			end
		end else begin
			if (phase_end) begin
				cyc_cnt <= '0;
				phase   <= phase + 1'b1;
			end else begin
				cyc_cnt <= cyc_cnt + 1'b1;
			end
			if (slot_end) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			if (op_done) begin
				state <= IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (q_pop_o) begin
			cur_op <= q_cmd_i.op;
		end
	end

	// bus pins
	always_ff @(posedge clk) begin
		if (rst) begin
			scl_o     <= 1'b1;
			sda_oen_o <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					// STOP pulls SDA down first, START makes sure it is released
					if (q_pop_o && (q_cmd_i.op == OP_STOP)) begin
						sda_oen_o <= 1'b0;
					end else if (q_pop_o && (q_cmd_i.op == OP_START)) begin
						sda_oen_o <= 1'b1;
					end
				end
				START: begin
					if (phase_end) begin
						case (phase)
							2'd0:    scl_o     <= 1'b1;
							2'd1:    sda_oen_o <= 1'b0;
							default: scl_o     <= 1'b0;
						endcase
					end
				end
				BYTE: begin
					if (slot_begin) begin
						sda_oen_o <= tx_bit_i;
					end
					if (phase_end && (phase == 2'd1)) begin
						scl_o <= 1'b1;
					end else if (slot_end) begin
						scl_o <= 1'b0;
					end
				end
				default: begin
					if (phase_end && (phase == 2'd0)) begin
						scl_o <= 1'b1;
					end else if (phase_end && (phase == 2'd1)) begin
						sda_oen_o <= 1'b1;
					end
				end
			endcase
		end
	end

	// response one cycle after the last phase
	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= op_done;
		end
	end

	always_ff @(posedge clk) begin
		if (op_done) begin
			rsp_o.op    <= cur_op;
			rsp_o.rdata <= rdata_i;
			rsp_o.ack   <= ack_i;
		end
	end

	assign load_o    = q_pop_o;
	assign wdata_o   = q_cmd_i.wdata;
	assign op_o      = cur_op;
	assign shift_o   = (state == BYTE) && slot_end;
	assign sample_o  = (state == BYTE) && (phase == 2'd2) && (cyc_cnt == SAMPLE_CYC);
	assign bit_idx_o = bit_cnt;

endmodule

//--- hdl/twi_master_top.sv
`timescale 1ns/1ps

module twi_master_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              cmd_valid_i,
	input  twi_pkg::twi_cmd_t cmd_i,
	output logic              credit_o,
	output logic              rsp_valid_o,
	output twi_pkg::twi_rsp_t rsp_o,
	output logic              scl_o,
	output logic              sda_oen_o,
	input  logic              sda_i
);

	import twi_pkg::*;

	logic       q_valid;
	twi_cmd_t   q_cmd;
	logic       q_pop;
	logic       tx_bit;
	logic [7:0] rdata;
	logic       ack;
	logic       load;
	logic [7:0] wdata;
	twi_op_e    op;
	logic       shift_tick;
	logic       sample_tick;
	logic [3:0] bit_idx;

	twi_cmd_queue i_queue (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid_i (cmd_valid_i),
		.cmd_i       (cmd_i),
		.pop_i       (q_pop),
		.valid_o     (q_valid),
		.cmd_o       (q_cmd),
		.credit_o    (credit_o)
	);

	twi_core i_core (
		.clk         (clk),
		.rst         (rst),
		.q_valid_i   (q_valid),
		.q_cmd_i     (q_cmd),
		.q_pop_o     (q_pop),
		.tx_bit_i    (tx_bit),
		.rdata_i     (rdata),
		.ack_i       (ack),
		.load_o      (load),
		.wdata_o     (wdata),
		.op_o        (op),
		.shift_o     (shift_tick),
		.sample_o    (sample_tick),
		.bit_idx_o   (bit_idx),
		.scl_o       (scl_o),
		.sda_oen_o   (sda_oen_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o)
	);

	twi_byte_shift i_shift (
		.clk       (clk),
		.rst       (rst),
		.load_i    (load),
		.wdata_i   (wdata),
		.op_i      (op),
		.shift_i   (shift_tick),
		.sample_i  (sample_tick),
		.bit_idx_i (bit_idx),
		.sda_i     (sda_i),
		.tx_bit_o  (tx_bit),
		.rdata_o   (rdata),
		.ack_o     (ack)
	);

endmodule

//--- verification/twi_slave_model.sv
`timescale 1ns/1ps

module twi_slave_model #(
	parameter logic [6:0] SLAVE_ADDR = 7'h50
) (
	input  logic clk,
	input  logic rst,
	input  logic scl_i,
	input  logic sda_i,
	output logic sda_oen_o
);

	localparam logic [31:0] MEM_SEED = 32'hd2f21619;

	typedef enum logic [1:0] {
		M_ADDR,
		M_WRITE,
		M_READ,
		M_NONE
	} mode_e;

	logic [7:0]  mem [8];
	logic        scl_q;
	logic        sda_q;
	logic        busy;
	mode_e       mode;
	logic [3:0]  bit_cnt;
	logic [7:0]  sr;
	logic [2:0]  ptr;
	logic        read_acked;
	int          start_cnt;
	int          stop_cnt;
	int          illegal_cnt;
	int          master_acks;
	int          master_nacks;
	integer      seed;
	logic [31:0] rnd;

	// SCL and SDA only change on clk edges and are sampled on clk
	always @(posedge clk) begin
		if (rst) begin
			seed = MEM_SEED;
			for (int i = 0; i < 8; i++) begin
				rnd = $random(seed);
				mem[i[2:0]] <= rnd[7:0];
			end
			scl_q        <= 1'b1;
			sda_q        <= 1'b1;
			busy         <= 1'b0;
			mode         <= M_NONE;
			bit_cnt      <= 4'd0;
			sr           <= 8'h00;
			ptr          <= 3'd0;
			read_acked   <= 1'b0;
			sda_oen_o    <= 1'b1;
			start_cnt    <= 0;
			stop_cnt     <= 0;
			illegal_cnt  <= 0;
			master_acks  <= 0;
			master_nacks <= 0;
		end else begin
			scl_q <= scl_i;
			sda_q <= sda_i;
			if (scl_i && scl_q && (sda_i != sda_q)) begin
				// only allowed when idle or in the first bit position of a byte
				if (busy && (bit_cnt != 4'd1)) begin
					illegal_cnt <= illegal_cnt + 1;
					$display("slave model: SDA changed while SCL was high inside a byte");
				end
				if (!sda_i) begin
					start_cnt <= start_cnt + 1;
					busy      <= 1'b1;
					mode      <= M_ADDR;
					bit_cnt   <= 4'd0;
					ptr       <= 3'd0;
				end else begin
					stop_cnt  <= stop_cnt + 1;
					busy      <= 1'b0;
					mode      <= M_NONE;
					sda_oen_o <= 1'b1;
				end
			end else if (busy && scl_i && !scl_q) begin
				if ((bit_cnt == 4'd8) && (mode == M_READ)) begin
					read_acked <= !sda_i;
					if (sda_i) begin
						master_nacks <= master_nacks + 1;
					end else begin
						master_acks <= master_acks + 1;
					end
				end else if ((bit_cnt != 4'd8) && ((mode == M_ADDR) || (mode == M_WRITE))) begin
					sr <= {sr[6:0], sda_i};
				end
				bit_cnt <= bit_cnt + 4'd1;
			end else if (busy && !scl_i && scl_q) begin
				case (bit_cnt)
					4'd8: begin
						if ((mode == M_ADDR) && (sr[7:1] == SLAVE_ADDR)) begin
							sda_oen_o <= 1'b0;
						end else if (mode == M_WRITE) begin
							mem[ptr]  <= sr;
							ptr       <= ptr + 3'd1;
							sda_oen_o <= 1'b0;
						end else begin
							sda_oen_o <= 1'b1;
						end
					end
					4'd9: begin
						bit_cnt   <= 4'd0;
						sda_oen_o <= 1'b1;
						if ((mode == M_ADDR) && (sr[7:1] == SLAVE_ADDR)) begin
							mode <= sr[0] ? M_READ : M_WRITE;
							if (sr[0]) begin
								sr        <= mem[ptr];
								sda_oen_o <= mem[ptr][7];
							end
						end else if ((mode == M_READ) && read_acked) begin
							ptr       <= ptr + 3'd1;
							sr        <= mem[ptr + 3'd1];
							sda_oen_o <= mem[ptr + 3'd1][7];
						end else if (mode != M_WRITE) begin
							mode <= M_NONE;
						end
					end
					default: begin
						if (mode == M_READ) begin
							sda_oen_o <= sr[3'd7 - bit_cnt[2:0]];
						end
					end
				endcase
			end
		end
	end

endmodule

//--- verification/tb_twi_master_top.sv
`timescale 1ns/1ps

module tb_twi_master_top;

	import twi_pkg::*;

	localparam logic [6:0] SLAVE_ADDR   = 7'h50;
	localparam int         CLK_PERIOD   = 40;
	localparam int         OP_CYC       = BYTE_BITS * BIT_PHASES * PHASE_CYC + 10;
	localparam int         TOTAL_CMDS   = 16;
	localparam int         WATCHDOG_CYC = 2 * TOTAL_CMDS * OP_CYC + 500;

	logic     clk;
	logic     rst;
	logic     cmd_valid_i;
	twi_cmd_t cmd_i;
	logic     credit_o;
	logic     rsp_valid_o;
	twi_rsp_t rsp_o;
	logic     scl_o;
	logic     sda_oen_o;
	logic     slave_oen;
	logic     sda;

	twi_rsp_t exp_q[$];
	twi_rsp_t got_q[$];
	int       errors;
	int       sent_cnt;
	int       rsp_idx;
	int       credit_pulses;

	// open-drain bus
	assign sda = sda_oen_o & slave_oen;

	twi_master_top i_dut (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid_i (cmd_valid_i),
		.cmd_i       (cmd_i),
		.credit_o    (credit_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o),
		.scl_o       (scl_o),
		.sda_oen_o   (sda_oen_o),
		.sda_i       (sda)
	);

	twi_slave_model #(.SLAVE_ADDR(SLAVE_ADDR)) i_slave (
		.clk       (clk),
		.rst       (rst),
		.scl_i     (scl_o),
		.sda_i     (sda),
		.sda_oen_o (slave_oen)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("watchdog: no response from the DUT after %0d cycles, run stopped", WATCHDOG_CYC);
		$display("Finished with errors");
		$finish;
	end

	always @(posedge clk) begin
		if (rst) begin
			credit_pulses <= 0;
		end else begin
			if (credit_o) begin
				credit_pulses <= credit_pulses + 1;
			end
			if (rsp_valid_o) begin
				got_q.push_back(rsp_o);
			end
		end
	end

	function automatic int credits_held();
		return CMD_DEPTH - sent_cnt + credit_pulses;
	endfunction

	function automatic twi_rsp_t make_rsp(input twi_op_e op, input logic [7:0] rdata,
		input logic ack);
		twi_rsp_t r;
		r.op    = op;
		r.rdata = rdata;
		r.ack   = ack;
		return r;
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("[ERROR] %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic check_rsp(input twi_rsp_t exp, input twi_rsp_t act);
		if (act.op !== exp.op) begin
			errors++;
			$display("[ERROR] rsp_o.op expected %h got %h", exp.op, act.op);
		end
		if (act.rdata !== exp.rdata) begin
			errors++;
			$display("[ERROR] rsp_o.rdata expected %h got %h", exp.rdata, act.rdata);
		end
		if (act.ack !== exp.ack) begin
			errors++;
			$display("[ERROR] rsp_o.ack expected %h got %h", exp.ack, act.ack);
		end
	endtask

	// holds the command for one cycle once a credit is free
	task automatic send_cmd(input twi_op_e op, input logic [7:0] wdata, input twi_rsp_t exp);
		while (credits_held() <= 0) begin
			@(posedge clk);
			#2;
		end
		cmd_valid_i = 1'b1;
		cmd_i.op    = op;
		cmd_i.wdata = wdata;
		exp_q.push_back(exp);
		sent_cnt++;
		@(posedge clk);
		#2;
		cmd_valid_i = 1'b0;
	endtask

	task automatic drain_rsp;
		twi_rsp_t exp;
		while (rsp_idx < sent_cnt) begin
			if (got_q.size() > rsp_idx) begin
				exp = exp_q.pop_front();
				check_rsp(exp, got_q[rsp_idx]);
				rsp_idx++;
			end else begin
				@(posedge clk);
				#2;
			end
		end
	endtask

	task automatic test_reset_state;
		repeat (10) begin
			check_bit("scl_o", 1'b1, scl_o);
			check_bit("sda_oen_o", 1'b1, sda_oen_o);
			check_bit("rsp_valid_o", 1'b0, rsp_valid_o);
			check_bit("credit_o", 1'b0, credit_o);
			@(posedge clk);
			#2;
		end
		check_count("credits after reset", CMD_DEPTH, credits_held());
	endtask

	task automatic test_addr_write;
		int starts0;
		int stops0;
		starts0 = i_slave.start_cnt;
		stops0  = i_slave.stop_cnt;
		send_cmd(OP_START, 8'h00, make_rsp(OP_START, 8'h00, 1'b0));
		send_cmd(OP_WRITE, {SLAVE_ADDR, 1'b0}, make_rsp(OP_WRITE, 8'h00, 1'b0));
		send_cmd(OP_WRITE, 8'ha5, make_rsp(OP_WRITE, 8'h00, 1'b0));
		send_cmd(OP_STOP, 8'h00, make_rsp(OP_STOP, 8'h00, 1'b0));
		drain_rsp();
		check_byte("slave mem[0]", 8'ha5, i_slave.mem[0]);
		check_count("slave START count", starts0 + 1, i_slave.start_cnt);
		check_count("slave STOP count", stops0 + 1, i_slave.stop_cnt);
		check_bit("scl_o after STOP", 1'b1, scl_o);
		check_bit("sda_oen_o after STOP", 1'b1, sda_oen_o);
	endtask

	task automatic test_wrong_addr;
		send_cmd(OP_START, 8'h00, make_rsp(OP_START, 8'h00, 1'b0));
		send_cmd(OP_WRITE, {7'h23, 1'b0}, make_rsp(OP_WRITE, 8'h00, 1'b1));
		send_cmd(OP_STOP, 8'h00, make_rsp(OP_STOP, 8'h00, 1'b0));
		drain_rsp();
	endtask

	task automatic test_reads;
		int acks0;
		int nacks0;
		acks0  = i_slave.master_acks;
		nacks0 = i_slave.master_nacks;
		send_cmd(OP_START, 8'h00, make_rsp(OP_START, 8'h00, 1'b0));
		send_cmd(OP_WRITE, {SLAVE_ADDR, 1'b1}, make_rsp(OP_WRITE, 8'h00, 1'b0));
		send_cmd(OP_READ_ACK, 8'h00, make_rsp(OP_READ_ACK, i_slave.mem[0], 1'b0));
		send_cmd(OP_READ_NACK, 8'h00, make_rsp(OP_READ_NACK, i_slave.mem[1], 1'b0));
		send_cmd(OP_STOP, 8'h00, make_rsp(OP_STOP, 8'h00, 1'b0));
		drain_rsp();
		check_count("slave master ACK count", acks0 + 1, i_slave.master_acks);
		check_count("slave master NACK count", nacks0 + 1, i_slave.master_nacks);
	endtask

	// CMD_DEPTH commands on back to back cycles
	task automatic test_credit_order;
		int pulses0;
		check_count("credits before burst", CMD_DEPTH, credits_held());
		pulses0 = credit_pulses;
		send_cmd(OP_START, 8'h00, make_rsp(OP_START, 8'h00, 1'b0));
		send_cmd(OP_WRITE, {SLAVE_ADDR, 1'b0}, make_rsp(OP_WRITE, 8'h00, 1'b0));
		send_cmd(OP_WRITE, 8'h3c, make_rsp(OP_WRITE, 8'h00, 1'b0));
		send_cmd(OP_STOP, 8'h00, make_rsp(OP_STOP, 8'h00, 1'b0));
		drain_rsp();
		check_count("credit pulses for burst", CMD_DEPTH, credit_pulses - pulses0);
		check_byte("slave mem[0]", 8'h3c, i_slave.mem[0]);
	endtask

	initial begin
		rst         = 1'b1;
		cmd_valid_i = 1'b0;
		cmd_i       = '0;
		errors      = 0;
		sent_cnt    = 0;
		rsp_idx     = 0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		test_reset_state();
		test_addr_write();
		test_wrong_addr();
		test_reads();
		test_credit_order();
		check_count("slave illegal SDA changes", 0, i_slave.illegal_cnt);
		check_count("credits at end", CMD_DEPTH, credits_held());
		check_count("responses received", sent_cnt, got_q.size());
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- twi_master_top.f
hdl/twi_pkg.sv
hdl/twi_cmd_queue.sv
hdl/twi_byte_shift.sv
hdl/twi_core.sv
hdl/twi_master_top.sv
verification/twi_slave_model.sv
verification/tb_twi_master_top.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_twi_master_top -f twi_master_top.f -o sim_twi \
	&& ./obj_dir/sim_twi > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Finished with no errors$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
